// File: hw/fc_params.svh
`ifndef FC_PARAMS_SVH
`define FC_PARAMS_SVH

// engine sizes
`define FC_CORE        4
`define FC_CORELOG     2
`define FC_DWIDTH      16
`define FC_ACCWIDTH    40
`define FC_FRAC        8
`define FC_IMGSIZE     10
`define FC_NETSIZE     10
`define FC_LWIDTH      10
`define FC_SETUP_TIME  4

// host address map, byte addresses
`define FC_AWIDTH          16
`define FC_REG_CTRL        'h00
`define FC_REG_STATUS      'h04
`define FC_REG_TOTAL_IN    'h08
`define FC_REG_TOTAL_OUT   'h0C
`define FC_REG_IN_OFFSET   'h10
`define FC_REG_OUT_OFFSET  'h14
`define FC_REG_NET_OFFSET  'h18
`define FC_IMG_BASE        'h1000
`define FC_IMG_MASK        'hF000
`define FC_NET_BASE        'h4000
`define FC_NET_MASK        'hC000

`endif

// File: hw/fc_pkg.sv
`include "fc_params.svh"

package fc_pkg;

  // signed fixed point word for images and weights
  typedef logic signed [`FC_DWIDTH-1:0]   data_t;
  typedef logic signed [`FC_ACCWIDTH-1:0] acc_t;

  typedef logic [`FC_IMGSIZE-1:0] img_addr_t;
  typedef logic [`FC_NETSIZE-1:0] net_addr_t;
  typedef logic [`FC_LWIDTH-1:0]  len_t;

  typedef enum logic [2:0] {
    S_WAIT,
    S_SETUP,
    S_INPUT,
    S_BIAS,
    S_OUTPUT
  } ctrl_state_t;

endpackage

// File: hw/mac_bus.sv
`timescale 1ns/1ps

// broadcast from the sequencer to every MAC core
interface mac_bus import fc_pkg::*; ();

  logic  start;
  logic  valid;
  logic  stop;
  logic  clear;
  data_t operand;

  modport master (output start, output valid, output stop, output clear, output operand);
  modport slave  (input start, input valid, input stop, input clear, input operand);

endinterface

// File: hw/fc_mem.sv
`timescale 1ns/1ps

module fc_mem #(
  parameter type word_t = logic [15:0],
  parameter int  depth  = 1024
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(depth)-1:0] addr,
  input  word_t                    wdata,
  output word_t                    rdata
);

  word_t ram [depth];

  // read before write, one cycle latency
  always_ff @(posedge clk) begin
    if (we) begin
      ram[addr] <= wdata;
    end
    rdata <= ram[addr];
  end

endmodule

// File: hw/fc_regs.sv
`timescale 1ns/1ps
`include "fc_params.svh"

module fc_regs import fc_pkg::*; (
  input  logic                   clk,
  input  logic                   xrst,
  input  logic [`FC_AWIDTH-1:0]  awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [`FC_AWIDTH-1:0]  araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  input  logic                   rready,
  input  logic                   idle,
  input  data_t                  img_rdata,
  output len_t                   total_in,
  output len_t                   total_out,
  output img_addr_t              in_offset,
  output img_addr_t              out_offset,
  output net_addr_t              net_offset,
  output logic                   run_req,
  output logic                   host_img_we,
  output logic                   host_net_we,
  output logic [`FC_CORELOG-1:0] host_sel,
  output net_addr_t              host_addr,
  output data_t                  host_wdata
);

  logic        wr_go;
  logic        wr_en;
  logic        rd_go;
  logic        rd_busy;
  logic        rd_s1;
  logic        rd_s2;
  logic        aw_img;
  logic        aw_net;
  logic        ar_win;
  logic        rd_img;
  logic [31:0] reg_val;
  logic [31:0] rd_val;

  assign aw_img = (awaddr & `FC_IMG_MASK) == `FC_IMG_BASE;
  assign aw_net = (awaddr & `FC_NET_MASK) == `FC_NET_BASE;
  assign ar_win = (araddr & `FC_IMG_MASK) == `FC_IMG_BASE
               || (araddr & `FC_NET_MASK) == `FC_NET_BASE;

  // one transaction in flight, writes win over reads
  assign rd_busy = rd_s1 || rd_s2 || rvalid;
  assign wr_go   = awvalid && wvalid && !bvalid && !rd_busy;
  assign rd_go   = arvalid && !(awvalid && wvalid) && !bvalid && !rd_busy;
  assign awready = wr_go;
  assign wready  = wr_go;
  assign arready = rd_go;

  // all fields live in the low half word
  assign wr_en = wr_go && wstrb[1:0] == 2'b11;

  always_comb begin
    case (araddr)
      `FC_REG_STATUS:     reg_val = 32'(idle);
      `FC_REG_TOTAL_IN:   reg_val = 32'(total_in);
      `FC_REG_TOTAL_OUT:  reg_val = 32'(total_out);
      `FC_REG_IN_OFFSET:  reg_val = 32'(in_offset);
      `FC_REG_OUT_OFFSET: reg_val = 32'(out_offset);
      `FC_REG_NET_OFFSET: reg_val = 32'(net_offset);
      default:            reg_val = '0;
    endcase
  end

  // ==============================
  // control and layer registers
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      bvalid      <= 1'b0;
      rvalid      <= 1'b0;
      rd_s1       <= 1'b0;
      rd_s2       <= 1'b0;
      run_req     <= 1'b0;
      host_img_we <= 1'b0;
      host_net_we <= 1'b0;
      total_in    <= '0;
      total_out   <= '0;
      in_offset   <= '0;
      out_offset  <= '0;
      net_offset  <= '0;
    end else begin
      rd_s1       <= rd_go;
      rd_s2       <= rd_s1;
      run_req     <= wr_en && awaddr == `FC_REG_CTRL && wdata[0] && idle;
      // windows are closed while a run is going
      host_img_we <= wr_en && aw_img && idle;
      host_net_we <= wr_en && aw_net && idle;
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end else if (wr_go) begin
        bvalid <= 1'b1;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end else if (rd_s2) begin
        rvalid <= 1'b1;
      end
      if (wr_en) begin
        case (awaddr)
          `FC_REG_TOTAL_IN:   total_in   <= len_t'(wdata);
          `FC_REG_TOTAL_OUT:  total_out  <= len_t'(wdata);
          `FC_REG_IN_OFFSET:  in_offset  <= img_addr_t'(wdata);
          `FC_REG_OUT_OFFSET: out_offset <= img_addr_t'(wdata);
          `FC_REG_NET_OFFSET: net_offset <= net_addr_t'(wdata);
          default: ;
        endcase
      end
    end
  end

  // host address, write data and read capture
  always_ff @(posedge clk) begin
    if (wr_go) begin
      host_addr  <= awaddr[2 +: `FC_NETSIZE];
      host_sel   <= awaddr[12 +: `FC_CORELOG];
      host_wdata <= wdata[`FC_DWIDTH-1:0];
      bresp      <= ((aw_img || aw_net) && !idle) ? 2'b10 : 2'b00;
    end else if (rd_go) begin
      host_addr <= araddr[2 +: `FC_NETSIZE];
      rd_img    <= (araddr & `FC_IMG_MASK) == `FC_IMG_BASE;
      rd_val    <= reg_val;
      rresp     <= (ar_win && !idle) ? 2'b10 : 2'b00;
    end
    if (rd_s2) begin
      rdata <= rd_img ? 32'(img_rdata) : rd_val;
    end
  end

  // a pending write response holds steady, never beside a read response
  assert property (@(posedge clk) disable iff (!xrst)
    bvalid && !bready |=> bvalid && $stable(bresp));
  assert property (@(posedge clk) disable iff (!xrst) !(bvalid && rvalid));

endmodule

// File: hw/fc_ctrl.sv
`timescale 1ns/1ps
`include "fc_params.svh"

module fc_ctrl import fc_pkg::*; (
  input  logic      clk,
  input  logic      xrst,
  input  logic      run_req,
  input  len_t      total_in,
  input  len_t      total_out,
  input  img_addr_t in_offset,
  input  img_addr_t out_offset,
  input  net_addr_t net_offset,
  input  logic      host_img_we,
  input  net_addr_t host_addr,
  input  data_t     host_wdata,
  output logic      idle,
  mac_bus.master    bus,
  output net_addr_t net_addr,
  output logic      breg_we,
  output logic      serial_we,
  input  logic      out_valid,
  input  data_t     out_data,
  output data_t     img_rdata
);

  ctrl_state_t state;
  len_t        cnt;
  len_t        grp;
  net_addr_t   net_base;
  img_addr_t   wr_addr;
  logic        go;
  logic        input_end;
  logic        setup_end;
  logic        output_end;
  logic        last_grp;
  logic        img_we;
  img_addr_t   img_addr;
  data_t       img_wdata;

  assign input_end  = state == S_INPUT && cnt == total_in - len_t'(1);
  assign setup_end  = state == S_SETUP && cnt == len_t'(`FC_SETUP_TIME - 1);
  // serializer load, stop and four write backs
  assign output_end = state == S_OUTPUT && cnt == len_t'(`FC_CORE + 2);
  assign last_grp   = grp + len_t'(`FC_CORE) >= total_out;
  assign go         = (state == S_WAIT && run_req) || setup_end;

  // ==============================
  // sequencer
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_WAIT;
      cnt   <= '0;
      grp   <= '0;
      idle  <= 1'b1;
    end else begin
      case (state)
        S_WAIT: begin
          if (run_req) begin
            state <= S_INPUT;
            cnt   <= '0;
            grp   <= '0;
            idle  <= 1'b0;
          end
        end
        S_SETUP: begin
          if (setup_end) begin
            state <= S_INPUT;
            cnt   <= '0;
          end else begin
            cnt <= cnt + len_t'(1);
          end
        end
        S_INPUT: begin
          // keeps counting so the bias cycle addresses word total_in
          cnt <= cnt + len_t'(1);
          if (input_end) begin
            state <= S_BIAS;
          end
        end
        S_BIAS: begin
          state <= S_OUTPUT;
          cnt   <= '0;
        end
        S_OUTPUT: begin
          if (output_end) begin
            cnt <= '0;
            if (last_grp) begin
              state <= S_WAIT;
              idle  <= 1'b1;
            end else begin
              state <= S_SETUP;
              grp   <= grp + len_t'(`FC_CORE);
            end
          end else begin
            cnt <= cnt + len_t'(1);
          end
        end
        default: state <= S_WAIT;
      endcase
    end
  end

  // weight base per group and write back pointer
  always_ff @(posedge clk) begin
    if (!xrst) begin
      net_base <= '0;
      wr_addr  <= '0;
    end else if (state == S_WAIT && run_req) begin
      net_base <= net_offset;
      wr_addr  <= out_offset;
    end else begin
      if (output_end) begin
        net_base <= net_base + net_addr_t'(total_in) + net_addr_t'(1);
      end
      if (out_valid) begin
        wr_addr <= wr_addr + img_addr_t'(1);
      end
    end
  end

  assign net_addr = net_base + net_addr_t'(cnt);

  // ==============================
  // core and serializer control
  // ==============================

  // valid trails the address by the memory latency
  always_ff @(posedge clk) begin
    if (!xrst) begin
      bus.start <= 1'b0;
      bus.valid <= 1'b0;
      bus.stop  <= 1'b0;
      bus.clear <= 1'b0;
      breg_we   <= 1'b0;
      serial_we <= 1'b0;
    end else begin
      bus.start <= go;
      bus.valid <= state == S_INPUT;
      breg_we   <= state == S_BIAS;
      bus.stop  <= breg_we;
      serial_we <= bus.stop;
      bus.clear <= output_end && last_grp;
    end
  end

  assign bus.operand = img_rdata;

  // image memory is the host's while idle
  assign img_we    = idle ? host_img_we : out_valid;
  assign img_wdata = idle ? host_wdata : out_data;
  assign img_addr  = idle      ? img_addr_t'(host_addr) :
                     out_valid ? wr_addr : in_offset + img_addr_t'(cnt);

  fc_mem #(
    .word_t (data_t),
    .depth  (1 << `FC_IMGSIZE)
  ) u_img_mem (
    .clk   (clk),
    .we    (img_we),
    .addr  (img_addr),
    .wdata (img_wdata),
    .rdata (img_rdata)
  );

  // results never land while inputs stream
  assert property (@(posedge clk) disable iff (!xrst) state == S_INPUT |-> !img_we);

endmodule

// File: hw/fc_mac.sv
`timescale 1ns/1ps
`include "fc_params.svh"

module fc_mac import fc_pkg::*; #(
  parameter int core_idx = 0
) (
  input  logic                   clk,
  input  logic                   xrst,
  mac_bus.slave                  bus,
  input  logic                   host_net_we,
  input  logic [`FC_CORELOG-1:0] host_sel,
  input  net_addr_t              host_addr,
  input  data_t                  host_wdata,
  input  net_addr_t              net_addr,
  input  logic                   breg_we,
  output acc_t                   acc
);

  logic      net_we;
  net_addr_t mem_addr;
  data_t     weight;
  data_t     bias_q;
  acc_t      prod;

  assign net_we   = host_net_we && host_sel == core_idx[`FC_CORELOG-1:0];
  assign mem_addr = net_we ? host_addr : net_addr;

  fc_mem #(
    .word_t (data_t),
    .depth  (1 << `FC_NETSIZE)
  ) u_net_mem (
    .clk   (clk),
    .we    (net_we),
    .addr  (mem_addr),
    .wdata (host_wdata),
    .rdata (weight)
  );

  assign prod = acc_t'(bus.operand) * acc_t'(weight);

  always_ff @(posedge clk) begin
    if (!xrst || bus.clear) begin
      acc    <= '0;
      bias_q <= '0;
    end else begin
      if (bus.start) begin
        acc <= '0;
      end else if (bus.valid) begin
        acc <= acc + prod;
      end else if (bus.stop) begin
        // bias sits in the integer part of the sum
        acc <= acc + (acc_t'(bias_q) <<< `FC_FRAC);
      end
      if (breg_we) begin
        bias_q <= weight;
      end
    end
  end

  // weight port belongs to the engine while a group streams
  assert property (@(posedge clk) disable iff (!xrst) net_we |-> !(bus.valid || breg_we));

endmodule

// File: hw/fc_serial.sv
`timescale 1ns/1ps
`include "fc_params.svh"

module fc_serial import fc_pkg::*; (
  input  logic  clk,
  input  logic  xrst,
  input  logic  serial_we,
  input  acc_t  acc_in [`FC_CORE],
  output logic  out_valid,
  output data_t out_data
);

  localparam acc_t max_val = acc_t'((1 << (`FC_DWIDTH - 1)) - 1);

  acc_t                sreg [`FC_CORE];
  logic [`FC_CORELOG:0] left;

  // drop the fraction, saturate high, clamp negatives
  function automatic data_t relu_sat(input acc_t a);
    acc_t s;
    s = a >>> `FC_FRAC;
    if (s < 0) begin
      return '0;
    end else if (s > max_val) begin
      return data_t'(max_val);
    end
    return data_t'(s);
  endfunction

  always_ff @(posedge clk) begin
    if (!xrst) begin
      left <= '0;
    end else if (serial_we) begin
      left <= (`FC_CORELOG+1)'(`FC_CORE);
    end else if (left != 0) begin
      left <= left - 1'b1;
    end
  end

  // core 0 leaves first
  always_ff @(posedge clk) begin
    if (serial_we) begin
      sreg <= acc_in;
    end else begin
      for (int i = 0; i < `FC_CORE - 1; i++) begin
        sreg[i] <= sreg[i+1];
      end
    end
  end

  assign out_valid = left != 0;
  assign out_data  = relu_sat(sreg[0]);

endmodule

// File: hw/fc_top.sv
`timescale 1ns/1ps
`include "fc_params.svh"

module fc_top import fc_pkg::*; (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic [`FC_AWIDTH-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [31:0]           wdata,
  input  logic [3:0]            wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [1:0]            bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [`FC_AWIDTH-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [31:0]           rdata,
  output logic [1:0]            rresp,
  output logic                  rvalid,
  input  logic                  rready
);

  len_t                   total_in;
  len_t                   total_out;
  img_addr_t              in_offset;
  img_addr_t              out_offset;
  net_addr_t              net_offset;
  logic                   run_req;
  logic                   host_img_we;
  logic                   host_net_we;
  logic [`FC_CORELOG-1:0] host_sel;
  net_addr_t              host_addr;
  data_t                  host_wdata;
  logic                   idle;
  data_t                  img_rdata;
  net_addr_t              net_addr;
  logic                   breg_we;
  logic                   serial_we;
  logic                   out_valid;
  data_t                  out_data;
  acc_t                   acc [`FC_CORE];

  mac_bus bus ();

  fc_regs u_regs (
    .clk, .xrst,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .idle, .img_rdata,
    .total_in, .total_out, .in_offset, .out_offset, .net_offset,
    .run_req, .host_img_we, .host_net_we, .host_sel, .host_addr, .host_wdata
  );

  fc_ctrl u_ctrl (
    .clk, .xrst, .run_req,
    .total_in, .total_out, .in_offset, .out_offset, .net_offset,
    .host_img_we, .host_addr, .host_wdata,
    .idle, .bus (bus), .net_addr, .breg_we, .serial_we,
    .out_valid, .out_data, .img_rdata
  );

  for (genvar i = 0; i < `FC_CORE; i++) begin : g_core
    fc_mac #(.core_idx(i)) u_mac (
      .clk, .xrst, .bus (bus),
      .host_net_we, .host_sel, .host_addr, .host_wdata,
      .net_addr, .breg_we, .acc (acc[i])
    );
  end

  fc_serial u_serial (
    .clk, .xrst, .serial_we, .acc_in (acc), .out_valid, .out_data
  );

endmodule

// File: sim/fc_tb.sv
`timescale 1ns/1ps
`include "fc_params.svh"

module fc_tb import fc_pkg::*; ();

  typedef logic [`FC_AWIDTH-1:0] axi_addr_t;

  logic clk;
  logic xrst;
  axi_addr_t awaddr;
  logic awvalid;
  logic awready;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  axi_addr_t araddr;
  logic arvalid;
  logic arready;
  logic [31:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;

  // reference state
  data_t img_model [1 << `FC_IMGSIZE];
  data_t net_model [`FC_CORE][1 << `FC_NETSIZE];
  int lay_tin;
  int lay_tout;
  int lay_in;
  int lay_out;
  int lay_net;

  int seed = 43;
  int ready_delay = 0;
  int cycles = 0;
  int cycle_limit;
  int data_errs = 0;
  int resp_errs = 0;
  int status_errs = 0;
  int proto_errs = 0;

  fc_top i_dut (
    .clk, .xrst,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==============================
  // compare tasks
  // ==============================

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("Fail %s resp: got %h expected %h", name, got, exp);
      resp_errs++;
    end
  endtask

  task automatic check_status(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s idle: got %h expected %h", name, got, exp);
      status_errs++;
    end
  endtask

  task automatic report_counts();
    $display("errors: data %0d, resp %0d, status %0d, protocol %0d",
             data_errs, resp_errs, status_errs, proto_errs);
  endtask

  // ==============================
  // AXI4-Lite host
  // ==============================

  // tasks start and end 1 ns after a rising edge
  task automatic axi_write(input axi_addr_t addr, input logic [31:0] data,
                           output logic [1:0] resp);
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #1;
    while (!awready) begin
      @(posedge clk);
      #2;
    end
    if (wready !== 1'b1) begin
      $display("write data was not accepted together with the write address");
      proto_errs++;
    end
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
      @(posedge clk);
      #1;
    end
    repeat (ready_delay) begin
      @(posedge clk);
      #1;
    end
    resp   = bresp;
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t addr, output logic [31:0] data,
                          output logic [1:0] resp);
    araddr  = addr;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    while (!rvalid) begin
      @(posedge clk);
      #1;
    end
    repeat (ready_delay) begin
      @(posedge clk);
      #1;
    end
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic write_reg(input axi_addr_t addr, input int val);
    logic [1:0] r;
    axi_write(addr, 32'(val), r);
    check_resp($sformatf("reg %h", addr), r, 2'b00);
  endtask

  task automatic write_img(input int addr, input data_t val);
    logic [1:0] r;
    axi_write(axi_addr_t'(`FC_IMG_BASE + addr * 4), 32'(val), r);
    check_resp($sformatf("img[%0d] write", addr), r, 2'b00);
    img_model[addr] = val;
  endtask

  task automatic write_net(input int core, input int addr, input data_t val);
    logic [1:0] r;
    axi_write(axi_addr_t'(`FC_NET_BASE + (core << 12) + addr * 4), 32'(val), r);
    check_resp($sformatf("net%0d[%0d] write", core, addr), r, 2'b00);
    net_model[core][addr] = val;
  endtask

  task automatic read_img(input int addr, output data_t val);
    logic [31:0] d;
    logic [1:0]  r;
    axi_read(axi_addr_t'(`FC_IMG_BASE + addr * 4), d, r);
    check_resp($sformatf("img[%0d] read", addr), r, 2'b00);
    val = data_t'(d[15:0]);
  endtask

  task automatic read_idle(output logic idle_bit);
    logic [31:0] d;
    logic [1:0]  r;
    axi_read(axi_addr_t'(`FC_REG_STATUS), d, r);
    check_resp("status read", r, 2'b00);
    idle_bit = d[0];
  endtask

  task automatic check_img(input int addr);
    data_t v;
    read_img(addr, v);
    check_data($sformatf("img[%0d]", addr), v, img_model[addr]);
  endtask

  task automatic check_outputs(input int off, input int n);
    for (int i = 0; i < n; i++) begin
      check_img(off + i);
    end
  endtask

  // ==============================
  // reference model
  // ==============================

  function automatic data_t neuron_ref(input int n);
    longint acc;
    int     c;
    int     base;
    c    = n % `FC_CORE;
    base = lay_net + (n / `FC_CORE) * (lay_tin + 1);
    acc  = longint'(net_model[c][base + lay_tin]) * (longint'(1) << `FC_FRAC);
    for (int i = 0; i < lay_tin; i++) begin
      acc += longint'(img_model[lay_in + i]) * longint'(net_model[c][base + i]);
    end
    acc = acc >>> `FC_FRAC;
    if (acc > 32767) begin
      acc = 32767;
    end
    if (acc < 0) begin
      acc = 0;
    end
    return data_t'(acc);
  endfunction

  task automatic apply_model();
    data_t res [$];
    for (int n = 0; n < lay_tout; n++) begin
      res.push_back(neuron_ref(n));
    end
    for (int n = 0; n < lay_tout; n++) begin
      img_model[lay_out + n] = res[n];
    end
  endtask

  // engine cycles per group plus about a dozen cycles per host access
  function automatic int run_cost(input int tin, input int tout);
    int accesses;
    accesses = tin + (tin + 1) * tout + 2 * tout + 24;
    return (tout / `FC_CORE) * (tin + `FC_CORE + 5 + `FC_SETUP_TIME) + 12 * accesses;
  endfunction

  function automatic data_t rand_small();
    return data_t'($random(seed) % 64);
  endfunction

  task automatic set_layer(input int tin, input int tout, input int in_off,
                           input int out_off, input int net_off);
    lay_tin  = tin;
    lay_tout = tout;
    lay_in   = in_off;
    lay_out  = out_off;
    lay_net  = net_off;
    write_reg(axi_addr_t'(`FC_REG_TOTAL_IN), tin);
    write_reg(axi_addr_t'(`FC_REG_TOTAL_OUT), tout);
    write_reg(axi_addr_t'(`FC_REG_IN_OFFSET), in_off);
    write_reg(axi_addr_t'(`FC_REG_OUT_OFFSET), out_off);
    write_reg(axi_addr_t'(`FC_REG_NET_OFFSET), net_off);
  endtask

  // inputs plus every group's weights and bias for the current layer
  task automatic load_random();
    for (int i = 0; i < lay_tin; i++) begin
      write_img(lay_in + i, rand_small());
    end
    for (int g = 0; g < lay_tout / `FC_CORE; g++) begin
      for (int c = 0; c < `FC_CORE; c++) begin
        for (int i = 0; i <= lay_tin; i++) begin
          write_net(c, lay_net + g * (lay_tin + 1) + i, rand_small());
        end
      end
    end
  endtask

  task automatic wait_idle();
    logic idle_bit;
    idle_bit = 1'b0;
    while (!idle_bit) begin
      read_idle(idle_bit);
    end
  endtask

  task automatic run_layer();
    write_reg(axi_addr_t'(`FC_REG_CTRL), 1);
    wait_idle();
    apply_model();
  endtask

  // ==============================
  // directed tests
  // ==============================

  task automatic test_reset_access();
    logic idle_bit;
    read_idle(idle_bit);
    check_status("after reset", idle_bit, 1'b1);
    write_img(500, 16'sh1234);
    write_img(501, -16'sd1);
    write_img(502, 16'sh7FFF);
    write_img(503, 16'sh8000);
    for (int a = 500; a < 504; a++) begin
      check_img(a);
    end
  endtask

  task automatic test_one_group();
    set_layer(8, 4, 0, 64, 0);
    for (int i = 0; i < 8; i++) begin
      write_img(i, data_t'((i + 1) * 32));
    end
    for (int c = 0; c < `FC_CORE; c++) begin
      for (int i = 0; i < 8; i++) begin
        write_net(c, i, data_t'(c * 48 - 40 + i * 4));
      end
      write_net(c, 8, data_t'(c * 3 - 4));
    end
    run_layer();
    check_outputs(64, 4);
  endtask

  task automatic test_three_groups();
    set_layer(12, 12, 100, 300, 40);
    write_img(99, 16'sh0AAA);
    write_img(112, 16'sh0BBB);
    write_img(299, 16'sh0CCC);
    write_img(312, 16'sh0DDD);
    load_random();
    run_layer();
    check_outputs(300, 12);
    check_img(99);
    check_img(112);
    check_img(299);
    check_img(312);
  endtask

  task automatic test_clamp();
    data_t v;
    data_t exp [`FC_CORE];
    exp = '{16'sd0, 16'sh7FFF, 16'sd5, 16'sd0};
    set_layer(4, 4, 200, 220, 500);
    for (int i = 0; i < 4; i++) begin
      write_img(200 + i, 16'sh7FFF);
      write_net(0, 500 + i, -16'sd256);
      write_net(1, 500 + i, 16'sh7FFF);
      write_net(2, 500 + i, 16'sd0);
      write_net(3, 500 + i, 16'sd0);
    end
    write_net(0, 504, 16'sd0);
    write_net(1, 504, 16'sd0);
    write_net(2, 504, 16'sd5);
    write_net(3, 504, -16'sd3);
    run_layer();
    for (int c = 0; c < `FC_CORE; c++) begin
      read_img(220 + c, v);
      check_data($sformatf("clamp out[%0d]", c), v, exp[c]);
    end
  endtask

  task automatic test_busy_access();
    logic [31:0] d;
    logic [1:0]  r;
    logic        idle_bit;
    set_layer(40, 8, 400, 480, 100);
    write_img(900, 16'sh0BAD);
    load_random();
    write_reg(axi_addr_t'(`FC_REG_CTRL), 1);
    read_idle(idle_bit);
    check_status("during run", idle_bit, 1'b0);
    axi_write(axi_addr_t'(`FC_IMG_BASE + 900 * 4), 32'h1111, r);
    check_resp("busy img write", r, 2'b10);
    axi_read(axi_addr_t'(`FC_IMG_BASE + 900 * 4), d, r);
    check_resp("busy img read", r, 2'b10);
    read_idle(idle_bit);
    check_status("still running", idle_bit, 1'b0);
    wait_idle();
    apply_model();
    check_img(900);
    check_outputs(480, 8);
  endtask

  task automatic test_back_to_back();
    ready_delay = 3;
    set_layer(10, 4, 700, 760, 400);
    load_random();
    set_layer(6, 8, 600, 640, 300);
    load_random();
    run_layer();
    set_layer(10, 4, 700, 760, 400);
    run_layer();
    check_outputs(640, 8);
    check_outputs(760, 4);
    ready_delay = 0;
  endtask

  // ==============================
  // main sequence and watchdog
  // ==============================

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: run still going after %0d cycles", cycles);
      report_counts();
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    cycle_limit = 2 * (run_cost(0, 4) + run_cost(8, 4) + run_cost(12, 12) + run_cost(4, 4)
                + run_cost(40, 8) + run_cost(6, 8) + run_cost(10, 4));
    xrst    = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    xrst = 1'b1;
    @(posedge clk);
    #1;
    test_reset_access();
    test_one_group();
    test_three_groups();
    test_clamp();
    test_busy_access();
    test_back_to_back();
    report_counts();
    if (data_errs + resp_errs + status_errs + proto_errs == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+hw
hw/fc_pkg.sv
hw/mac_bus.sv
hw/fc_mem.sv
hw/fc_regs.sv
hw/fc_ctrl.sv
hw/fc_mac.sv
hw/fc_serial.sv
hw/fc_top.sv
sim/fc_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the fc_top testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module fc_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vfc_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
  exit 1
fi
exit 0
